//--- source/core_pkg.sv
package core_pkg;

  typedef logic [31:0] instr_t;
  typedef logic [31:0] word_t;
  typedef logic [3:0]  reg_addr_t;
  typedef logic [7:0]  pc_t;

  typedef enum logic [3:0] {T_NOP = 4'd0, T_ALU, T_MOV, T_LOAD, T_STORE} instr_type_t;

  typedef enum logic [2:0] {ADD = 3'd0, SUB, AND, OR, XOR} alu_op_t;

  typedef enum logic [1:0] {FWD_NONE = 2'd0, FWD_MEM = 2'd1, FWD_EXE = 2'd2} fwd_sel_t;

  typedef struct packed {
    instr_t ir;
    word_t  a;   // rb, or ra for a STORE.
    word_t  b;   // rc for ALU, rb otherwise.
    word_t  imm;
  } id_exe_t;

  typedef struct packed {
    logic      valid;
    logic      reg_write;
    reg_addr_t dest;
    word_t     data;
  } exe_mem_t;

  function automatic instr_type_t ir_type(instr_t ir);
    return instr_type_t'(ir[31:28]);
  endfunction

  function automatic logic [3:0] ir_op(instr_t ir);
    return ir[27:24];
  endfunction

  function automatic reg_addr_t ir_ra(instr_t ir);
    return ir[23:20];
  endfunction

  function automatic reg_addr_t ir_rb(instr_t ir);
    return ir[19:16];
  endfunction

  function automatic reg_addr_t ir_rc(instr_t ir);
    return ir[15:12];
  endfunction

  function automatic word_t ir_alu_imm(instr_t ir);
    return {{20{ir[11]}}, ir[11:0]};
  endfunction

  // Load/store offset, bit 0 is the size bit.
  function automatic word_t ir_ls_off(instr_t ir);
    return {{21{ir[11]}}, ir[11:1]};
  endfunction

  function automatic logic ir_size(instr_t ir);
    return ir[0];
  endfunction

endpackage

//--- source/fetch_stage.sv
module fetch_stage import core_pkg::*; (
  input  logic   clk_i,
  input  logic   rst_n,
  input  logic   stall,
  input  instr_t fetch_data,
  output pc_t    fetch_addr,
  output instr_t if_ir
);

  pc_t pc;

  assign fetch_addr = pc;

  // The instruction behind a load stays in if_ir until the load clears.
  always_ff @(posedge clk_i or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pc    <= '0;
      if_ir <= '0;
    end
    else if (!stall)
    begin
      pc    <= pc + 8'd1;
      if_ir <= fetch_data;
    end
  end

  // A load-use stall lasts one cycle and holds the PC.
  pc_hold_a: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    stall |=> $stable(pc) && !stall
  );

endmodule

//--- source/hazard_unit.sv
module hazard_unit import core_pkg::*; (
  input  instr_t   if_ir,
  input  instr_t   id_ir,
  input  exe_mem_t exe_fwd,
  input  exe_mem_t mem_rec,
  output logic     stall,
  output fwd_sel_t sel_a,
  output fwd_sel_t sel_b
);

  instr_type_t id_type;
  logic [3:0]  id_op;
  reg_addr_t   id_ra;
  reg_addr_t   id_rb;
  reg_addr_t   id_rc;
  reg_addr_t   if_rb;
  reg_addr_t   if_rc;
  logic        id_size;
  logic        id_live;

  assign id_type = ir_type(id_ir);
  assign id_op   = ir_op(id_ir);
  assign id_ra   = ir_ra(id_ir);
  assign id_rb   = ir_rb(id_ir);
  assign id_rc   = ir_rc(id_ir);
  assign id_size = ir_size(id_ir);
  assign if_rb   = ir_rb(if_ir);
  assign if_rc   = ir_rc(if_ir);
  assign id_live = (id_ir != '0);

  // Load-use: hold the consumer one cycle so the load data comes from MEM.
  assign stall = (id_type == T_LOAD) && (if_ir != '0) &&
                 (id_ra == if_rb || id_ra == if_rc);

  // Youngest producer wins.
  function automatic fwd_sel_t src_for(reg_addr_t r);
    if (id_live && exe_fwd.reg_write && exe_fwd.dest == r)
      return FWD_EXE;
    if (id_live && mem_rec.reg_write && mem_rec.dest == r)
      return FWD_MEM;
    return FWD_NONE;
  endfunction

  always_comb
  begin
    sel_a = FWD_NONE;
    sel_b = FWD_NONE;
    case (id_type)
      T_ALU:
      begin
        sel_a = src_for(id_rb);
        sel_b = id_op[3] ? FWD_NONE : src_for(id_rc); // Immediate form.
      end
      T_MOV:   sel_a = src_for(id_rb);
      T_STORE:
      begin
        sel_a = src_for(id_ra);
        sel_b = id_size ? FWD_NONE : src_for(id_rb);
      end
      T_LOAD:  sel_b = id_size ? FWD_NONE : src_for(id_rb);
      default: ;
    endcase
  end

endmodule

//--- source/decode_stage.sv
module decode_stage import core_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_n,
  input  instr_t   if_ir,
  input  exe_mem_t exe_fwd,
  input  exe_mem_t mem_rec,
  output logic     stall,
  output id_exe_t  id_exe
);

  instr_t      id_ir;
  instr_type_t id_type;
  reg_addr_t   a_addr;
  reg_addr_t   b_addr;
  fwd_sel_t    sel_a;
  fwd_sel_t    sel_b;
  word_t       opnd_a;
  word_t       opnd_b;
  word_t       imm;
  word_t       rf [16];

  hazard_unit u_hazard (
    .if_ir   (if_ir),
    .id_ir   (id_ir),
    .exe_fwd (exe_fwd),
    .mem_rec (mem_rec),
    .stall   (stall),
    .sel_a   (sel_a),
    .sel_b   (sel_b)
  );

  always_ff @(posedge clk_i or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < 16; i++)
        rf[i] <= '0;
    end
    else if (mem_rec.valid && mem_rec.reg_write)
    begin
      rf[mem_rec.dest] <= mem_rec.data;
    end
  end

  assign id_type = ir_type(id_ir);
  assign a_addr  = (id_type == T_STORE) ? ir_ra(id_ir) : ir_rb(id_ir); // STORE data.
  assign b_addr  = (id_type == T_ALU) ? ir_rc(id_ir) : ir_rb(id_ir);
  assign imm     = (id_type == T_ALU) ? ir_alu_imm(id_ir) : ir_ls_off(id_ir);

  function automatic word_t pick(fwd_sel_t sel, word_t rf_val);
    case (sel)
      FWD_EXE: return exe_fwd.data;
      FWD_MEM: return mem_rec.data;
      default: return rf_val;
    endcase
  endfunction

  assign opnd_a = pick(sel_a, rf[a_addr]);
  assign opnd_b = pick(sel_b, rf[b_addr]);

  always_ff @(posedge clk_i or negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_ir  <= '0;
      id_exe <= '0;
    end
    else
    begin
      id_ir  <= stall ? '0 : if_ir; // Bubble goes in behind the load.
      id_exe <= '{ir: id_ir, a: opnd_a, b: opnd_b, imm: imm};
    end
  end

  // The consumer waits in IF while the bubble passes.
  bubble_after_stall_a: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    stall |=> (id_ir == '0) && $stable(if_ir)
  );

endmodule

//--- source/execute_stage.sv
module execute_stage import core_pkg::*; #(
  parameter int DMEM_WORDS = 16
) (
  input  logic      clk_i,
  input  logic      rst_n,
  input  id_exe_t   id_exe,
  output exe_mem_t  exe_fwd,
  output exe_mem_t  mem_rec,
  output logic      wb_valid,
  output reg_addr_t wb_reg,
  output word_t     wb_data
);

  localparam int AW = $clog2(DMEM_WORDS);

  instr_type_t    ex_type;
  logic [3:0]     ex_op;
  alu_op_t        alu_op;
  word_t          rhs;
  word_t          alu_out;
  word_t          mem_addr;
  logic [AW-1:0]  dmem_idx;
  word_t          result;
  logic           is_store;
  word_t          dmem [DMEM_WORDS];

  assign ex_type  = ir_type(id_exe.ir);
  assign ex_op    = ir_op(id_exe.ir);
  assign alu_op   = alu_op_t'(ex_op[2:0]);
  assign rhs      = ex_op[3] ? id_exe.imm : id_exe.b;
  assign is_store = (ex_type == T_STORE);

  // Absolute when the size bit is set.
  assign mem_addr = ir_size(id_exe.ir) ? id_exe.imm : id_exe.b + id_exe.imm;
  assign dmem_idx = mem_addr[AW-1:0]; // Wraps modulo DMEM_WORDS.

  always_comb
  begin
    case (alu_op)
      ADD:     alu_out = id_exe.a + rhs;
      SUB:     alu_out = id_exe.a - rhs;
      AND:     alu_out = id_exe.a & rhs;
      OR:      alu_out = id_exe.a | rhs;
      XOR:     alu_out = id_exe.a ^ rhs;
      default: alu_out = '0;
    endcase
  end

  always_comb
  begin
    case (ex_type)
      T_ALU:   result = alu_out;
      T_MOV:   result = id_exe.a;
      T_LOAD:  result = dmem[dmem_idx];
      default: result = '0;
    endcase
  end

  assign exe_fwd = '{valid:     (id_exe.ir != '0),
                     reg_write: (ex_type inside {T_ALU, T_MOV, T_LOAD}),
                     dest:      ir_ra(id_exe.ir),
                     data:      result};

  always_ff @(posedge clk_i or negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < DMEM_WORDS; i++)
        dmem[i] <= '0;
    end
    else if (is_store)
    begin
      dmem[dmem_idx] <= id_exe.a;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n)
  begin
    if (!rst_n)
      mem_rec <= '0;
    else
      mem_rec <= exe_fwd;
  end

  assign wb_valid = mem_rec.valid && mem_rec.reg_write;
  assign wb_reg   = mem_rec.dest;
  assign wb_data  = mem_rec.data;

  // A load in EXE is never directly followed by a reader of its ra through rb or rc.
  load_use_gap_a: assert property (
    @(posedge clk_i) disable iff (!rst_n)
    (ex_type == T_LOAD) |=> (id_exe.ir == '0) ||
      (ir_rb(id_exe.ir) != $past(exe_fwd.dest) && ir_rc(id_exe.ir) != $past(exe_fwd.dest))
  );

endmodule

//--- source/pipeline_core.sv
module pipeline_core import core_pkg::*; #(
  parameter int DMEM_WORDS = 16
) (
  input  logic      clk_i,
  input  logic      rst_n,
  output pc_t       fetch_addr,
  input  instr_t    fetch_data,
  output logic      wb_valid,
  output reg_addr_t wb_reg,
  output word_t     wb_data
);

  logic     stall;
  instr_t   if_ir;
  id_exe_t  id_exe;
  exe_mem_t exe_fwd;
  exe_mem_t mem_rec;

  fetch_stage u_fetch (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .stall      (stall),
    .fetch_data (fetch_data),
    .fetch_addr (fetch_addr),
    .if_ir      (if_ir)
  );

  decode_stage u_decode (
    .clk_i   (clk_i),
    .rst_n   (rst_n),
    .if_ir   (if_ir),
    .exe_fwd (exe_fwd),
    .mem_rec (mem_rec),
    .stall   (stall),
    .id_exe  (id_exe)
  );

  execute_stage #(
    .DMEM_WORDS (DMEM_WORDS)
  ) u_execute (
    .clk_i    (clk_i),
    .rst_n    (rst_n),
    .id_exe   (id_exe),
    .exe_fwd  (exe_fwd),
    .mem_rec  (mem_rec),
    .wb_valid (wb_valid),
    .wb_reg   (wb_reg),
    .wb_data  (wb_data)
  );

endmodule

//--- dv/core_checker.sv
module core_checker import core_pkg::*; #(
  parameter int N          = 200,
  parameter int DMEM_WORDS = 16
) (
  input  logic      clk_i,
  input  logic      rst_n,
  input  logic      drained,
  input  pc_t       fetch_addr,
  input  instr_t    prog [N],
  input  logic      wb_valid,
  input  reg_addr_t wb_reg,
  input  word_t     wb_data,
  output int        n_checked,
  output int        n_expected,
  output int        n_errors
);

  timeunit 1ns;
  timeprecision 1ns;

  localparam int AW = $clog2(DMEM_WORDS);

  typedef struct packed {
    reg_addr_t dest;
    word_t     data;
  } wb_t;

  wb_t  exp_q [$];
  logic built    = 1'b0;
  logic reported = 1'b0;
  int   settle;
  pc_t  last_pc;
  logic pc_seen;
  logic held;

  // ISA interpreter, one instruction at a time in program order.
  function automatic void build_expected();
    word_t         mrf [16];
    word_t         mmem [DMEM_WORDS];
    instr_t        ir;
    logic [3:0]    kind;
    logic [3:0]    op;
    reg_addr_t     ra;
    reg_addr_t     rb;
    reg_addr_t     rc;
    word_t         x;
    word_t         y;
    word_t         res;
    word_t         addr;
    logic [AW-1:0] idx;
    mrf  = '{default: '0};
    mmem = '{default: '0};
    for (int i = 0; i < N; i++)
    begin
      ir   = prog[i];
      kind = ir[31:28];
      op   = ir[27:24];
      ra   = ir[23:20];
      rb   = ir[19:16];
      rc   = ir[15:12];
      addr = {{21{ir[11]}}, ir[11:1]};
      if (!ir[0])
        addr = addr + mrf[rb]; // Base plus offset.
      idx = AW'(addr % DMEM_WORDS);
      case (kind)
        4'd1:
        begin
          x = mrf[rb];
          y = op[3] ? {{20{ir[11]}}, ir[11:0]} : mrf[rc];
          case (op[2:0])
            3'd0:    res = x + y;
            3'd1:    res = x - y;
            3'd2:    res = x & y;
            3'd3:    res = x | y;
            3'd4:    res = x ^ y;
            default: res = '0;
          endcase
          mrf[ra] = res;
          exp_q.push_back('{dest: ra, data: res});
        end
        4'd2:
        begin
          mrf[ra] = mrf[rb];
          exp_q.push_back('{dest: ra, data: mrf[rb]});
        end
        4'd3:
        begin
          mrf[ra] = mmem[idx];
          exp_q.push_back('{dest: ra, data: mmem[idx]});
        end
        4'd4:    mmem[idx] = mrf[ra]; // No writeback.
        default: ;
      endcase
    end
  endfunction

  // The word at p-1 sits right behind a LOAD of its rb or rc.
  function automatic logic load_use_at(pc_t p);
    instr_t ld;
    instr_t nxt;
    if (p < 2 || p > N)
      return 1'b0;
    ld  = prog[p-2];
    nxt = prog[p-1];
    return ld[31:28] == 4'd3 && nxt != '0 &&
           (ld[23:20] == nxt[19:16] || ld[23:20] == nxt[15:12]);
  endfunction

  task automatic check_fetch();
    pc_t want;
    want = (!held && load_use_at(last_pc)) ? last_pc : pc_t'(last_pc + 1);
    if (fetch_addr != want)
    begin
      n_errors++;
      $display("FAIL %0t: fetch_addr expected %0d, got %0d", $time, want, fetch_addr);
    end
    held = (want == last_pc);
  endtask

  task automatic check_writeback();
    wb_t e;
    if (exp_q.size() == 0)
    begin
      n_errors++;
      $display("Extra writeback to r%0d with data %h after the last expected one",
               wb_reg, wb_data);
    end
    else
    begin
      e = exp_q.pop_front();
      n_checked++;
      if (e.dest != wb_reg || e.data != wb_data)
      begin
        n_errors++;
        $display("FAIL %0t: writeback %0d expected r%0d = %h, got r%0d = %h",
                 $time, n_checked, e.dest, e.data, wb_reg, wb_data);
      end
    end
  endtask

  always @(posedge clk_i)
  begin
    if (!built)
    begin
      build_expected();
      n_expected = exp_q.size();
      n_checked  = 0;
      n_errors   = 0;
      built      = 1'b1;
    end
    if (!rst_n)
    begin
      settle  = 0;
      pc_seen = 1'b0;
      held    = 1'b0;
      if (wb_valid)
      begin
        n_errors++;
        $display("FAIL %0t: wb_valid is high during reset", $time);
      end
    end
    else
    begin
      if (pc_seen)
        check_fetch();
      last_pc = fetch_addr;
      pc_seen = 1'b1;
      if (settle < 3)
      begin
        settle++;
        if (wb_valid)
        begin
          n_errors++;
          $display("FAIL %0t: wb_valid is high before any instruction can retire", $time);
        end
      end
      else if (wb_valid)
        check_writeback();
      if (drained && !reported)
      begin
        reported = 1'b1;
        if (exp_q.size() != 0)
        begin
          n_errors += exp_q.size();
          $display("%0d expected writebacks never appeared, the first one is for r%0d",
                   exp_q.size(), exp_q[0].dest);
        end
      end
    end
  end

endmodule

//--- dv/tb_top.sv
module tb_top import core_pkg::*; ();

  timeunit 1ns;
  timeprecision 1ns;

  localparam int N               = 200;
  localparam int DMEM_WORDS      = 8;
  localparam int WATCHDOG_CYCLES = 2 * N + 40;

  logic        clk_i;
  logic        rst_n;
  pc_t         fetch_addr;
  instr_t      fetch_data;
  logic        wb_valid;
  reg_addr_t   wb_reg;
  word_t       wb_data;
  logic        drained;
  logic        rom_ready;
  int          n_checked;
  int          n_expected;
  int          n_errors;
  instr_t      prog [N];
  logic [15:0] lfsr;

  pipeline_core #(
    .DMEM_WORDS (DMEM_WORDS)
  ) dut (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .fetch_addr (fetch_addr),
    .fetch_data (fetch_data),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data)
  );

  core_checker #(
    .N          (N),
    .DMEM_WORDS (DMEM_WORDS)
  ) u_checker (
    .clk_i      (clk_i),
    .rst_n      (rst_n),
    .drained    (drained),
    .fetch_addr (fetch_addr),
    .prog       (prog),
    .wb_valid   (wb_valid),
    .wb_reg     (wb_reg),
    .wb_data    (wb_data),
    .n_checked  (n_checked),
    .n_expected (n_expected),
    .n_errors   (n_errors)
  );

  always #50 clk_i = ~clk_i;

  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
  endfunction

  // One LFSR step per bit taken.
  function automatic logic [31:0] take_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
    return v;
  endfunction

  function automatic instr_t make_instr();
    logic [4:0] kind;
    logic [2:0] op;
    logic [3:0] off;
    instr_t     ir;
    kind = 5'(take_bits(5));
    ir   = '0;
    if (kind >= 5'd3) // Three in 32 stay NOPs.
    begin
      ir[23:20] = 4'(take_bits(2)); // Only r0 to r3, dense dependencies.
      ir[19:16] = 4'(take_bits(2));
      ir[15:12] = 4'(take_bits(2));
      if (kind < 5'd19)
      begin
        ir[31:28] = (kind < 5'd15) ? T_ALU : T_MOV;
        op        = 3'(take_bits(3));
        ir[26:24] = (op > 3'd4) ? op - 3'd3 : op;
        ir[27]    = 1'(take_bits(1));
        ir[11:0]  = 12'(take_bits(12));
      end
      else
      begin
        ir[31:28] = (kind < 5'd26) ? T_LOAD : T_STORE;
        off       = 4'(take_bits(4));
        ir[11:1]  = {{7{off[3]}}, off}; // Small signed offset.
        ir[0]     = 1'(take_bits(1));
      end
    end
    return ir;
  endfunction

  // The ROM answers in the fetch cycle, fetch_addr only moves at a rising edge.
  always @(fetch_addr or rom_ready)
    fetch_data <= (rom_ready && fetch_addr < N) ? prog[fetch_addr] : '0;

  initial
  begin
    clk_i     = 1'b0;
    rst_n     = 1'b0;
    drained   = 1'b0;
    rom_ready = 1'b0;
    lfsr      = 16'd75;
    for (int i = 0; i < N; i++)
      prog[i] = make_instr();
    rom_ready <= 1'b1;
    repeat (8) @(posedge clk_i);
    rst_n <= 1'b1;
    while (fetch_addr != pc_t'(N + 8))
      @(posedge clk_i);
    drained <= 1'b1; // Pipeline holds only NOPs by now.
    repeat (2) @(posedge clk_i);
    @(negedge clk_i);
    $display("Writebacks checked: %0d of %0d expected, errors: %0d",
             n_checked, n_expected, n_errors);
    if (n_errors == 0 && n_checked == n_expected)
      $display("Testbench passed");
    else
      $display("Testbench failed");
    $finish;
  end

  initial
  begin
    repeat (WATCHDOG_CYCLES) @(posedge clk_i);
    $display("Timeout: the core did not drain the program within %0d cycles",
             WATCHDOG_CYCLES);
    $display("Testbench failed");
    $finish;
  end

endmodule

//--- compile.f
source/core_pkg.sv
source/fetch_stage.sv
source/hazard_unit.sv
source/decode_stage.sv
source/execute_stage.sv
source/pipeline_core.sv
dv/core_checker.sv
dv/tb_top.sv

//--- run.sh
#!/usr/bin/env bash
set -e -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
  --top-module tb_top -f compile.f -o tb_sim

./obj_dir/tb_sim | tee sim.log

if grep -q "Testbench failed" sim.log; then
  echo "Simulation reported a failure, see sim.log"
  exit 1
fi
echo "Simulation clean"
